// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Cycles spent on every instruction
  localparam int unsigned PHASES = 5;

  typedef enum logic [3:0] {
    it_op,       // Register-register ALU
    it_op_imm,   // Register-immediate ALU
    it_lui,
    it_auipc,
    it_jal,
    it_jalr,
    it_branch,
    it_load,     // lw only
    it_store,    // sw only
    it_illegal   // Retires as a no-op
  } inst_type_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_func_e;

  typedef enum logic [2:0] {
    br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } br_func_e;

  // Decoder output, 58 bits
  typedef struct packed {
    inst_type_e         itype;
    alu_func_e          alu_func;
    br_func_e           br_func;
    logic signed [31:0] imm;      // Already sign extended
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
  } decoded_t;

  // Execute results, 96 bits
  typedef struct packed {
    logic [31:0] data;     // ALU result, link value or store data
    logic [31:0] addr;     // Byte address for lw/sw
    logic [31:0] next_pc;
  } exec_t;

  // One record per retired instruction, 70 bits
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        wen;      // Set even when rd is x0
  } retire_t;

endpackage

`default_nettype wire

// File: logic/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Word-wide single port RAM, read-first, one cycle read latency
module sync_ram #(
  parameter int AW = 10  // Word address width
) (
  input  wire              clk_100mhz,
  input  wire              sys_rst,   // Clears the output register only
  input  wire  [AW-1:0]    addr,
  input  wire              we,
  input  wire  [31:0]      wdata,
  output logic [31:0]      rdata
);

  logic [31:0] mem [2**AW];

  // Start from an all-zero image
  initial begin
    for (int i = 0; i < 2**AW; i++) mem[i] = '0;
  end

  always_ff @(posedge clk_100mhz) begin
    if (we) mem[addr] <= wdata;
  end

  // Old contents come out on a write cycle
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) rdata <= '0;
    else         rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire         clk_100mhz,
  input  wire         sys_rst,
  input  wire  [4:0]  rs1,
  input  wire  [4:0]  rs2,
  input  wire         we,
  input  wire  [4:0]  wa,
  input  wire  [31:0] wd,
  output logic [31:0] rval1,
  output logic [31:0] rval2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && wa != 5'd0) begin  // x0 never written
      regs[wa] <= wd;
    end
  end

  // Asynchronous reads straight from the array
  assign rval1 = regs[rs1];
  assign rval2 = regs[rs2];

  // x0 kept at zero by reset and the write gate
  a_x0_zero: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (rs1 == 5'd0) |-> (rval1 == 32'd0));

endmodule

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire  [31:0]           inst,
  output rv_pkg::decoded_t      dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        alt;        // inst[30] selects sub or sra
  logic        f7_ok;      // funct7 legal for a register op
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign alt    = inst[30];
  assign f7_ok  = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  // Immediate formats
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec.rs1   = inst[19:15];
    dec.rs2   = inst[24:20];
    dec.rd    = inst[11:7];
    dec.imm   = imm_i;                   // I-type unless overridden
    dec.itype = rv_pkg::it_illegal;
    case (opcode)
      7'b0110011: if (f7_ok) dec.itype = rv_pkg::it_op;
      7'b0010011: dec.itype = rv_pkg::it_op_imm;
      7'b0110111: begin
        dec.itype = rv_pkg::it_lui;
        dec.imm   = imm_u;
      end
      7'b0010111: begin
        dec.itype = rv_pkg::it_auipc;
        dec.imm   = imm_u;
      end
      7'b1101111: begin
        dec.itype = rv_pkg::it_jal;
        dec.imm   = imm_j;
      end
      7'b1100111: if (funct3 == 3'b000) dec.itype = rv_pkg::it_jalr;
      7'b1100011: begin
        if (funct3[2:1] != 2'b01) dec.itype = rv_pkg::it_branch;  // 010/011 reserved
        dec.imm = imm_b;
      end
      7'b0000011: if (funct3 == 3'b010) dec.itype = rv_pkg::it_load;  // Word only
      7'b0100011: begin
        if (funct3 == 3'b010) dec.itype = rv_pkg::it_store;
        dec.imm = imm_s;
      end
      default: ;
    endcase

    case (funct3)
      3'b000:  dec.alu_func = (alt && opcode == 7'b0110011) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  dec.alu_func = rv_pkg::alu_sll;
      3'b010:  dec.alu_func = rv_pkg::alu_slt;
      3'b011:  dec.alu_func = rv_pkg::alu_sltu;
      3'b100:  dec.alu_func = rv_pkg::alu_xor;
      3'b101:  dec.alu_func = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;  // srai too
      3'b110:  dec.alu_func = rv_pkg::alu_or;
      default: dec.alu_func = rv_pkg::alu_and;
    endcase

    case (funct3)
      3'b001:  dec.br_func = rv_pkg::br_ne;
      3'b100:  dec.br_func = rv_pkg::br_lt;
      3'b101:  dec.br_func = rv_pkg::br_ge;
      3'b110:  dec.br_func = rv_pkg::br_ltu;
      3'b111:  dec.br_func = rv_pkg::br_geu;
      default: dec.br_func = rv_pkg::br_eq;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

// Purely combinational, everything settles within a phase
module rv_execute (
  input  wire rv_pkg::decoded_t dec,
  input  wire [31:0]            pc,
  input  wire [31:0]            rval1,
  input  wire [31:0]            rval2,
  output rv_pkg::exec_t         ex
);

  logic [31:0] op_b;      // Second ALU operand
  logic [31:0] alu_out;
  logic [31:0] pc_plus4;
  logic [31:0] jalr_tgt;
  logic        taken;

  assign op_b     = (dec.itype == rv_pkg::it_op) ? rval2 : dec.imm;
  assign pc_plus4 = pc + 32'd4;
  assign jalr_tgt = rval1 + dec.imm;

  always_comb begin
    case (dec.alu_func)
      rv_pkg::alu_sub:  alu_out = rval1 - op_b;
      rv_pkg::alu_and:  alu_out = rval1 & op_b;
      rv_pkg::alu_or:   alu_out = rval1 | op_b;
      rv_pkg::alu_xor:  alu_out = rval1 ^ op_b;
      rv_pkg::alu_slt:  alu_out = {31'd0, $signed(rval1) < $signed(op_b)};
      rv_pkg::alu_sltu: alu_out = {31'd0, rval1 < op_b};
      rv_pkg::alu_sll:  alu_out = rval1 << op_b[4:0];   // Shamt is low 5 bits
      rv_pkg::alu_srl:  alu_out = rval1 >> op_b[4:0];
      rv_pkg::alu_sra:  alu_out = $unsigned($signed(rval1) >>> op_b[4:0]);
      default:          alu_out = rval1 + op_b;
    endcase
  end

  // Branch compare, always on the two registers
  always_comb begin
    case (dec.br_func)
      rv_pkg::br_ne:  taken = rval1 != rval2;
      rv_pkg::br_lt:  taken = $signed(rval1) < $signed(rval2);
      rv_pkg::br_ge:  taken = $signed(rval1) >= $signed(rval2);
      rv_pkg::br_ltu: taken = rval1 < rval2;
      rv_pkg::br_geu: taken = rval1 >= rval2;
      default:        taken = rval1 == rval2;
    endcase
  end

  always_comb begin
    ex.addr    = rval1 + dec.imm;   // lw/sw byte address
    ex.data    = alu_out;
    ex.next_pc = pc_plus4;          // Illegal falls through here
    case (dec.itype)
      rv_pkg::it_lui:   ex.data = dec.imm;
      rv_pkg::it_auipc: ex.data = pc + dec.imm;
      rv_pkg::it_jal: begin
        ex.data    = pc_plus4;      // Link
        ex.next_pc = pc + dec.imm;
      end
      rv_pkg::it_jalr: begin
        ex.data    = pc_plus4;
        ex.next_pc = {jalr_tgt[31:1], 1'b0};
      end
      rv_pkg::it_branch: ex.next_pc = taken ? pc + dec.imm : pc_plus4;
      rv_pkg::it_store:  ex.data = rval2;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rv_retire #(
  parameter int IMEM_AW = 10,
  parameter int DMEM_AW = 7
) (
  input  wire                 clk_100mhz,
  input  wire                 sys_rst,
  input  wire                 run,
  input  wire  [31:0]         inst,
  input  wire rv_pkg::decoded_t dec,
  input  wire rv_pkg::exec_t  ex,
  input  wire  [31:0]         rval2,
  input  wire  [31:0]         mem_rdata,
  output logic [IMEM_AW-1:0]  fetch_addr,
  output logic [DMEM_AW-1:0]  dmem_addr,
  output logic                dmem_we,
  output logic [31:0]         dmem_wdata,
  output logic                rf_we,
  output logic [4:0]          rf_wa,
  output logic [31:0]         rf_wd,
  output logic                retire,
  output rv_pkg::retire_t     retire_info,
  output logic                halted,
  output logic [15:0]         led
);

  localparam int PW = $clog2(rv_pkg::PHASES);

  logic [PW-1:0] phase;
  logic [31:0]   pc;
  logic          wen;        // Instruction class writes rd
  logic [31:0]   wb_data;

  assign fetch_addr = pc[IMEM_AW+1:2];       // Word index
  assign dmem_addr  = ex.addr[DMEM_AW+1:2];
  assign dmem_wdata = rval2;
  assign dmem_we    = run && phase == PW'(2) && dec.itype == rv_pkg::it_store;

  assign wen = !(dec.itype inside {rv_pkg::it_branch, rv_pkg::it_store, rv_pkg::it_illegal});
  assign wb_data = (dec.itype == rv_pkg::it_load) ? mem_rdata : ex.data;  // Load data valid by now

  assign retire = run && phase == PW'(rv_pkg::PHASES - 1);
  assign rf_we  = retire && wen && dec.rd != 5'd0;
  assign rf_wa  = dec.rd;
  assign rf_wd  = wb_data;

  always_comb begin
    retire_info.pc    = pc;
    retire_info.rd    = dec.rd;
    retire_info.wdata = wb_data;
    retire_info.wen   = wen;
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      phase  <= '0;
      pc     <= '0;
      halted <= 1'b0;
      led    <= '0;
    end else if (!run) begin   // Idle so the next run starts from pc 0
      phase  <= '0;
      pc     <= '0;
      halted <= 1'b0;
    end else if (!halted) begin
      if (phase == PW'(1) && inst == 32'd0) begin
        halted <= 1'b1;        // Zero word stops the core
        phase  <= '0;
      end else if (retire) begin
        phase <= '0;
        pc    <= ex.next_pc;
        if (rf_we) led <= wb_data[15:0];
      end else begin
        phase <= phase + PW'(1);
      end
    end
  end

  // Halting parks the phase counter at 0
  a_no_retire_halted: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !(retire && halted));
  // One store strobe per instruction in phase 2
  a_store_phase: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    dmem_we |-> (phase == PW'(2)) ##1 !dmem_we);

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int IMEM_AW = 10,
  parameter int DMEM_AW = 7
) (
  input  wire                 clk_100mhz,
  input  wire                 sys_rst,
  input  wire                 run,
  input  wire                 imem_we,      // Program load, ignored while run
  input  wire  [IMEM_AW-1:0]  imem_addr,
  input  wire  [31:0]         imem_wdata,
  output logic                retire,
  output rv_pkg::retire_t     retire_info,
  output logic                halted,
  output logic [15:0]         led
);

  logic [IMEM_AW-1:0] fetch_addr;
  logic [IMEM_AW-1:0] imem_a;
  logic               imem_wen;
  logic [31:0]        inst;
  rv_pkg::decoded_t   dec;
  rv_pkg::exec_t      ex;
  logic [31:0]        rval1, rval2;
  logic [DMEM_AW-1:0] dmem_addr;
  logic               dmem_we;
  logic [31:0]        dmem_wdata, dmem_rdata;
  logic               rf_we;
  logic [4:0]         rf_wa;
  logic [31:0]        rf_wd;

  // Loader owns the instruction port while stopped
  assign imem_a   = run ? fetch_addr : imem_addr;
  assign imem_wen = imem_we && !run;

  sync_ram #(.AW(IMEM_AW)) inst_mem (
    .clk_100mhz, .sys_rst, .addr(imem_a), .we(imem_wen),
    .wdata(imem_wdata), .rdata(inst)
  );

  rv_decode i_decode (.inst, .dec);

  reg_file i_reg_file (
    .clk_100mhz, .sys_rst, .rs1(dec.rs1), .rs2(dec.rs2),
    .we(rf_we), .wa(rf_wa), .wd(rf_wd), .rval1, .rval2
  );

  rv_execute i_execute (.dec, .pc(retire_info.pc), .rval1, .rval2, .ex);

  sync_ram #(.AW(DMEM_AW)) data_mem (
    .clk_100mhz, .sys_rst, .addr(dmem_addr), .we(dmem_we),
    .wdata(dmem_wdata), .rdata(dmem_rdata)
  );

  rv_retire #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) i_retire (
    .clk_100mhz, .sys_rst, .run, .inst, .dec, .ex, .rval2,
    .mem_rdata(dmem_rdata), .fetch_addr, .dmem_addr, .dmem_we, .dmem_wdata,
    .rf_we, .rf_wa, .rf_wd, .retire, .retire_info, .halted, .led
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// 100 MHz clock and power-on reset
module tb_clock (
  output logic clk_100mhz,
  output logic sys_rst
);

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;  // 10 ns period
  end

  initial begin
    sys_rst = 1'b1;
    repeat (4) @(posedge clk_100mhz);
    sys_rst <= 1'b0;                      // Released after 4 edges
  end

endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int IMEM_AW = 10;
  localparam int DMEM_AW = 7;
  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr  = 7'b1100111;

  logic               clk_100mhz, sys_rst;
  logic               run, imem_we;
  logic [IMEM_AW-1:0] imem_addr;
  logic [31:0]        imem_wdata;
  logic               retire, halted;
  rv_pkg::retire_t    retire_info;
  logic [15:0]        led;

  logic [31:0]     prog [$];            // Program being assembled
  logic [31:0]     imem_img [2**IMEM_AW];  // Mirror of instruction memory
  logic [31:0]     ref_regs [32];
  logic [31:0]     ref_mem [2**DMEM_AW];
  logic [15:0]     ref_led;
  rv_pkg::retire_t exp_q [$];
  rv_pkg::retire_t got_q [$];
  int              ret_cyc [$];         // Cycle of each retire pulse
  int              cycle, cycle_limit, err_val, err_other;

  tb_clock i_tb_clock (.clk_100mhz, .sys_rst);

  rv_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) i_rv_core (
    .clk_100mhz, .sys_rst, .run, .imem_we, .imem_addr, .imem_wdata,
    .retire, .retire_info, .halted, .led
  );

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    enc_r = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // ISA arithmetic in funct3 order
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
    case (f3)
      3'd0:    ref_alu = alt ? a - b : a + b;
      3'd1:    ref_alu = a << b[4:0];
      3'd2:    ref_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    ref_alu = (a < b) ? 32'd1 : 32'd0;
      3'd4:    ref_alu = a ^ b;
      3'd5:    ref_alu = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    ref_alu = a | b;
      default: ref_alu = a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
      3'd0:    branch_taken = a == b;
      3'd1:    branch_taken = a != b;
      3'd4:    branch_taken = $signed(a) < $signed(b);
      3'd5:    branch_taken = $signed(a) >= $signed(b);
      3'd6:    branch_taken = a < b;
      3'd7:    branch_taken = a >= b;
      default: branch_taken = 1'b0;
    endcase
  endfunction

  // Reference ISS running from pc 0 up to the zero word
  task automatic model_run();
    logic [31:0] cur_pc, w, a, b, val, npc, imm_i, ea;
    logic        wen;
    int          steps;
    cur_pc = '0;
    steps  = 0;
    exp_q.delete();
    w = imem_img[cur_pc[IMEM_AW+1:2]];
    while (w != 32'd0 && steps < 500) begin
      a     = ref_regs[w[19:15]];
      b     = ref_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      npc   = cur_pc + 32'd4;
      val   = '0;
      wen   = 1'b1;
      case (w[6:0])
        7'b0110011: val = ref_alu(w[14:12], w[30], a, b);
        opc_imm:    val = ref_alu(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
        opc_lui:    val = {w[31:12], 12'd0};
        opc_auipc:  val = cur_pc + {w[31:12], 12'd0};
        7'b1101111: begin
          val = cur_pc + 32'd4;
          npc = cur_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        opc_jalr: begin
          val = cur_pc + 32'd4;
          npc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          wen = 1'b0;
          if (branch_taken(w[14:12], a, b))
            npc = cur_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        opc_load: begin
          ea  = a + imm_i;
          val = ref_mem[ea[DMEM_AW+1:2]];
        end
        opc_store: begin
          wen = 1'b0;
          ea  = a + {{20{w[31]}}, w[31:25], w[11:7]};
          val = b;
          ref_mem[ea[DMEM_AW+1:2]] = b;
        end
        default: wen = 1'b0;             // Unknown encodings do nothing
      endcase
      if (wen && w[11:7] != 5'd0) begin
        ref_regs[w[11:7]] = val;
        ref_led = val[15:0];
      end
      exp_q.push_back('{pc: cur_pc, rd: w[11:7], wdata: val, wen: wen});
      cur_pc = npc;
      steps++;
      w = imem_img[cur_pc[IMEM_AW+1:2]];
    end
  endtask

  task automatic check_retire(input rv_pkg::retire_t exp, input rv_pkg::retire_t got);
    rv_pkg::retire_t cmp;
    string           exp_s;
    string           got_s;
    cmp = got;
    if (!exp.wen) cmp.wdata = exp.wdata;  // No defined value without a write
    if (cmp !== exp) begin
      err_val++;
      exp_s = $sformatf("pc=%h rd=%0d wdata=%h wen=%b", exp.pc, exp.rd, exp.wdata, exp.wen);
      got_s = $sformatf("pc=%h rd=%0d wdata=%h wen=%b", got.pc, got.rd, got.wdata, got.wen);
      $display("[ERROR] %0t retire_info: expected %s, got %s", $time, exp_s, got_s);
    end
  endtask

  task automatic check_led(input logic [15:0] exp, input logic [15:0] got);
    if (got !== exp) begin
      err_val++;
      $display("[ERROR] %0t led: expected %h, got %h", $time, exp, got);
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk_100mhz);
      imem_we    <= 1'b1;
      imem_addr  <= IMEM_AW'(i);
      imem_wdata <= prog[i];
      imem_img[i] = prog[i];
    end
    @(posedge clk_100mhz);
    imem_we <= 1'b0;
  endtask

  // li as lui + addi with the upper part rounded for the signed low half
  task automatic emit_li(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = val + 32'h800;
    prog.push_back({hi[31:12], rd, opc_lui});
    prog.push_back(enc_i(val[11:0], rd, 3'd0, rd, opc_imm));
  endtask

  task automatic run_program(input string name);
    prog.push_back(32'd0);               // Halt word
    load_program();
    model_run();
    cycle_limit += prog.size() + (exp_q.size() + 4) * rv_pkg::PHASES + 20;
    got_q.delete();
    ret_cyc.delete();
    @(posedge clk_100mhz);
    run <= 1'b1;
    while (!halted) @(negedge clk_100mhz);
    repeat (2 * rv_pkg::PHASES) @(negedge clk_100mhz);  // Must stay quiet while halted
    if (got_q.size() != exp_q.size()) begin
      err_other++;
      $display("%s: %0d instructions retired where %0d were expected",
               name, got_q.size(), exp_q.size());
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_retire(exp_q[i], got_q[i]);
    end
    for (int i = 1; i < ret_cyc.size(); i++) begin
      if (ret_cyc[i] - ret_cyc[i-1] != rv_pkg::PHASES) begin
        err_other++;
        $display("%s: retire %0d came %0d cycles after the one before it",
                 name, i, ret_cyc[i] - ret_cyc[i-1]);
      end
    end
    check_led(ref_led, led);             // Last written value held
    @(posedge clk_100mhz);
    run <= 1'b0;
    @(posedge clk_100mhz);
    @(negedge clk_100mhz);
    if (halted) begin
      err_other++;
      $display("%s: halted still set after run dropped", name);
    end
    prog.delete();
  endtask

  task automatic test_alu();
    logic [31:0] a, b;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    for (int round = 0; round < 3; round++) begin
      a = $urandom();
      b = $urandom();
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      for (int k = 0; k < 10; k++) begin  // add..and then sub and sra
        f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
        alt = k >= 8;
        prog.push_back(enc_r(alt, 5'd2, 5'd1, f3, 5'(3 + k)));
      end
      for (int k = 0; k < 9; k++) begin   // Immediate forms with srai last
        f3  = (k < 8) ? 3'(k) : 3'd5;
        alt = k == 8;
        imm = 12'($urandom());
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, imm[4:0]};
        prog.push_back(enc_i(imm, 5'd1, f3, 5'(13 + k), opc_imm));
      end
      prog.push_back(enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd0));   // Write to x0
      prog.push_back(enc_r(1'b0, 5'd2, 5'd0, 3'd0, 5'd22));  // x0 reads back zero
      run_program("alu");
    end
  endtask

  task automatic test_branch();
    logic [2:0] f3;
    logic [4:0] ra, rb;
    emit_li(5'd1, 32'hffff_fffb);        // -5
    emit_li(5'd2, 32'd3);
    for (int p = 0; p < 3; p++) begin
      for (int f = 0; f < 6; f++) begin
        f3 = (f < 2) ? 3'(f) : 3'(f + 2);
        ra = (p == 2) ? 5'd2 : 5'd1;
        rb = (p == 0) ? 5'd2 : 5'd1;
        prog.push_back(enc_b(13'd8, rb, ra, f3));
        prog.push_back(enc_i(12'd1, 5'd20, 3'd0, 5'd20, opc_imm));  // Skipped if taken
      end
    end
    prog.push_back(enc_i(12'd3, 5'd0, 3'd0, 5'd9, opc_imm));  // Three-pass loop
    prog.push_back(enc_i(12'hfff, 5'd9, 3'd0, 5'd9, opc_imm));
    prog.push_back(enc_b(13'h1ffc, 5'd0, 5'd9, 3'd1));         // bne back by 4
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_i(12'd1, 5'd20, 3'd0, 5'd20, opc_imm));
    prog.push_back({20'd0, 5'd6, opc_auipc});
    prog.push_back(enc_i(12'd13, 5'd6, 3'd0, 5'd7, opc_jalr)); // Odd target loses bit 0
    prog.push_back(enc_i(12'd1, 5'd20, 3'd0, 5'd20, opc_imm));
    prog.push_back(enc_i(12'd0, 5'd20, 3'd0, 5'd21, opc_imm));
    run_program("branch");
  endtask

  task automatic test_mem();
    emit_li(5'd1, $urandom());
    emit_li(5'd2, $urandom());
    prog.push_back(enc_s(12'd8, 5'd1, 5'd0));
    prog.push_back(enc_s(12'd12, 5'd2, 5'd0));
    prog.push_back(enc_i(12'd8, 5'd0, 3'b010, 5'd3, opc_load));
    prog.push_back(enc_i(12'd12, 5'd0, 3'b010, 5'd4, opc_load));
    prog.push_back(enc_i(12'd16, 5'd0, 3'd0, 5'd6, opc_imm));
    prog.push_back(enc_s(12'hffc, 5'd1, 5'd6));                // Overwrites word at 12
    prog.push_back(enc_i(12'd12, 5'd0, 3'b010, 5'd7, opc_load));
    prog.push_back(enc_i(12'd8, 5'd6, 3'b010, 5'd8, opc_load)); // Untouched word
    run_program("memory");
  endtask

  task automatic test_halt_restart();
    prog.push_back(enc_i(12'h5a5, 5'd0, 3'd0, 5'd10, opc_imm));
    prog.push_back(enc_s(12'd0, 5'd10, 5'd0));                 // Last one writes no register
    run_program("halt");
    prog.push_back(enc_i(12'h123, 5'd0, 3'd0, 5'd11, opc_imm)); // Shorter reload from pc 0
    run_program("restart");
  endtask

  // Retire monitor sampled mid-cycle
  always @(negedge clk_100mhz) begin
    cycle = cycle + 1;
    if (retire) begin
      if (!run || sys_rst) begin
        err_other++;
        $display("Retire pulsed at %0t while run was low or reset was active", $time);
      end
      got_q.push_back(retire_info);
      ret_cyc.push_back(cycle);
    end
  end

  always @(posedge clk_100mhz) begin
    if (cycle > cycle_limit) begin
      $display("Timeout reached after %0d cycles", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc9dde951));
    run         = 1'b0;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_wdata  = '0;
    cycle       = 0;
    cycle_limit = 40;                    // Reset and idle time
    err_val     = 0;
    err_other   = 0;
    ref_led     = '0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < 2**DMEM_AW; i++) ref_mem[i] = '0;
    for (int i = 0; i < 2**IMEM_AW; i++) imem_img[i] = '0;
    @(negedge clk_100mhz);
    while (sys_rst) @(negedge clk_100mhz);
    repeat (3) @(negedge clk_100mhz);    // Idle while nothing may retire
    test_alu();
    test_branch();
    test_mem();
    test_halt_restart();
    $display("Checks done with %0d value errors and %0d other errors", err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/rv_pkg.sv
logic/sync_ram.sv
logic/reg_file.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_retire.sv
logic/rv_core.sv
testbench/tb_clock.sv
testbench/tb_rv_core.sv
